/* sysCtrl_config.svh */
// Sizing and register map of the system-control block
// Wishbone is 32 bits wide with word addresses only, no byte selects
// The backdoor word index also addresses flash as index*8 + byte
// SC_FLASH_BYTES must stay equal to 8 * 2**SC_ADDR_W
`ifndef SYSCTRL_CONFIG_SVH
`define SYSCTRL_CONFIG_SVH

// Bus and data widths
`define SC_WB_DW 32
`define SC_WB_AW 3
`define SC_DATA_W 64
`define SC_ADDR_W 8

// Memory depths and core count
`define SC_MAIN_WORDS 256
`define SC_FLASH_BYTES 2048
`define SC_NUM_CORES 4

// Register word addresses
`define SC_REG_CTRL 3'd0
`define SC_REG_MADDR 3'd1
`define SC_REG_MDATA_HI 3'd2
`define SC_REG_MDATA_LO 3'd3
`define SC_REG_MCMD 3'd4
`define SC_REG_STATUS 3'd5

`endif

/* sysCtrlPkg.sv */
// Shared types of the system-control block
// Opcode value 3 is not defined and is never issued as a command
// Sequencer states are ordered for readability only

`include "sysCtrl_config.svh"

package sysCtrlPkg;

  // Data words, flash bytes, one bit per core
  typedef logic [`SC_DATA_W-1:0] scWord_t;
  typedef logic [7:0] scByte_t;
  typedef logic [`SC_NUM_CORES-1:0] coreVec_t;

  // Backdoor command opcodes, MCMD bits 1:0
  typedef enum logic [1:0] {
    CMD_NONE    = 2'd0,
    CMD_WRITE64 = 2'd1,
    CMD_READ64  = 2'd2
  } memCmd_t;

  // Core sequencer states
  typedef enum logic [2:0] {
    SEQ_IDLE        = 3'd0,
    SEQ_WAIT_LOAD   = 3'd1,
    SEQ_RELEASE     = 3'd2,
    SEQ_WAIT_RESULT = 3'd3,
    SEQ_DONE        = 3'd4
  } seqState_t;

endpackage

/* sysCtrlIfs.sv */
// Internal interfaces of the system-control block
// backdoorIf carries one-cycle start pulses and a busy level
// memPortIf holds req until a single-cycle ack, AW sets the address width
// seqCtrlIf start is a one-cycle pulse, loaded and mask are levels
`timescale 1ns/1ps
`include "sysCtrl_config.svh"

// Register bank to backdoor engine
interface backdoorIf;
  logic                   start;
  sysCtrlPkg::memCmd_t    op;
  logic                   sel;
  logic [`SC_ADDR_W-1:0]  addr;
  sysCtrlPkg::scWord_t    wdata;
  sysCtrlPkg::scWord_t    rdata;
  logic                   busy;

  modport master (output start, op, sel, addr, wdata, input rdata, busy);
  modport slave (input start, op, sel, addr, wdata, output rdata, busy);
endinterface

// Backdoor engine to one memory
interface memPortIf #(parameter int AW = `SC_ADDR_W);
  logic                 req;
  logic                 we;
  logic [AW-1:0]        addr;
  sysCtrlPkg::scWord_t  wdata;
  sysCtrlPkg::scWord_t  rdata;
  logic                 ack;

  modport master (output req, we, addr, wdata, input rdata, ack);
  modport slave (input req, we, addr, wdata, output rdata, ack);
endinterface

// Register bank to core sequencer
interface seqCtrlIf;
  logic                 start;
  sysCtrlPkg::coreVec_t mask;
  logic                 loaded;
  logic                 busy;
  logic                 done;
  sysCtrlPkg::coreVec_t passMask;
  sysCtrlPkg::coreVec_t failMask;

  modport master (output start, mask, loaded, input busy, done, passMask, failMask);
  modport slave (input start, mask, loaded, output busy, done, passMask, failMask);
endinterface

/* dvtFlagRegs.sv */
// Wishbone classic slave holding the control, command and status registers
// Ack comes one cycle after cyc and stb, writes land on the acking edge
// seqStart and the MCMD opcode clear themselves, CTRL bit 2 reads as 0
// Unmapped addresses read as 0, writes to them are dropped
`timescale 1ns/1ps
`include "sysCtrl_config.svh"

module dvtFlagRegs
  import sysCtrlPkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  wbCyc_i,
  input  logic                  wbStb_i,
  input  logic                  wbWe_i,
  input  logic [`SC_WB_AW-1:0]  wbAdr_i,
  input  logic [`SC_WB_DW-1:0]  wbDat_i,
  output logic [`SC_WB_DW-1:0]  wbDat_o,
  output logic                  wbAck_o,
  backdoorIf.master             bd,
  seqCtrlIf.master              seq
);

  logic                 wbAccess;
  logic                 wbWrite;
  logic                 bdSel;
  logic                 progLoaded;
  coreVec_t             coreMask;
  logic [`SC_ADDR_W-1:0] mAddr;
  logic [`SC_WB_DW-1:0] mDataHi;
  logic [`SC_WB_DW-1:0] mDataLo;
  memCmd_t              mCmd;
  memCmd_t              bdOp;
  logic                 bdStart;
  logic                 bdBusyQ;
  logic                 seqStartPend;
  logic                 seqStart;
  logic                 memBusy;
  logic                 seqBusy;
  logic [`SC_WB_DW-1:0] rdMux;

  // New access only while ack is low, so ack never lasts two cycles
  assign wbAccess = wbCyc_i & wbStb_i & ~wbAck_o;
  assign wbWrite = wbAccess & wbWe_i;

  // Busy also covers the gap between the write and the engine taking it
  assign memBusy = bd.busy | bdStart | (mCmd != CMD_NONE);
  assign seqBusy = seq.busy | seqStart | seqStartPend;

  // ------------------------------
  // Read mux
  always_comb begin
    rdMux = '0;
    case (wbAdr_i)
      `SC_REG_CTRL: begin
        rdMux[0] = bdSel;
        rdMux[1] = progLoaded;
        rdMux[4 +: `SC_NUM_CORES] = coreMask;
      end
      `SC_REG_MADDR:    rdMux[`SC_ADDR_W-1:0] = mAddr;
      `SC_REG_MDATA_HI: rdMux = mDataHi;
      `SC_REG_MDATA_LO: rdMux = mDataLo;
      `SC_REG_MCMD:     rdMux[1:0] = mCmd;
      `SC_REG_STATUS: begin
        rdMux[0] = memBusy;
        rdMux[1] = seqBusy;
        rdMux[2] = seq.done;
        rdMux[4 +: `SC_NUM_CORES] = seq.passMask;
        rdMux[8 +: `SC_NUM_CORES] = seq.failMask;
      end
      default: rdMux = '0;
    endcase
  end

  // ------------------------------
  // Control state and command pulses
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wbAck_o <= 1'b0;
      bdSel <= 1'b0;
      progLoaded <= 1'b0;
      coreMask <= '0;
      mCmd <= CMD_NONE;
      bdStart <= 1'b0;
      bdBusyQ <= 1'b0;
      seqStartPend <= 1'b0;
      seqStart <= 1'b0;
    end else begin
      wbAck_o <= wbAccess;
      bdBusyQ <= bd.busy;
      // Pending command becomes a pulse one cycle after the ack cycle
      bdStart <= (mCmd == CMD_WRITE64) || (mCmd == CMD_READ64);
      seqStart <= seqStartPend;
      mCmd <= CMD_NONE;
      seqStartPend <= 1'b0;
      if (wbWrite) begin
        case (wbAdr_i)
          `SC_REG_CTRL: begin
            bdSel <= wbDat_i[0];
            progLoaded <= wbDat_i[1];
            seqStartPend <= wbDat_i[2];
            coreMask <= wbDat_i[4 +: `SC_NUM_CORES];
          end
          `SC_REG_MCMD: mCmd <= memCmd_t'(wbDat_i[1:0]);
          default: ;
        endcase
      end
    end
  end

  // ------------------------------
  // Address, data and read-back registers
  always_ff @(posedge clk) begin
    bdOp <= mCmd;
    if (wbAccess) begin
      wbDat_o <= rdMux;
    end
    // Engine result lands once busy has dropped
    if (bdBusyQ && !bd.busy) begin
      {mDataHi, mDataLo} <= bd.rdata;
    end
    if (wbWrite) begin
      case (wbAdr_i)
        `SC_REG_MADDR:    mAddr <= wbDat_i[`SC_ADDR_W-1:0];
        `SC_REG_MDATA_HI: mDataHi <= wbDat_i;
        `SC_REG_MDATA_LO: mDataLo <= wbDat_i;
        default: ;
      endcase
    end
  end

  assign bd.start = bdStart;
  assign bd.op = bdOp;
  assign bd.sel = bdSel;
  assign bd.addr = mAddr;
  assign bd.wdata = {mDataHi, mDataLo};

  assign seq.start = seqStart;
  assign seq.mask = coreMask;
  assign seq.loaded = progLoaded;

endmodule

/* backdoorRouter.sv */
// Runs 64-bit backdoor reads and writes against main memory or flash
// Select 0 gives one 64-bit access, select 1 gives eight byte beats
// Flash is little endian, byte b of word i sits at address i*8 + b
// A start while busy is dropped, rdata holds the last word moved
`timescale 1ns/1ps
`include "sysCtrl_config.svh"

module backdoorRouter
  import sysCtrlPkg::*;
(
  input  logic        clk,
  input  logic        rst_i,
  backdoorIf.slave    bd,
  memPortIf.master    mainPort,
  memPortIf.master    flashPort
);

  memCmd_t                curOp;
  logic                   selR;
  logic [`SC_ADDR_W-1:0]  addrR;
  scWord_t                dataR;
  logic [2:0]             beat;
  logic                   busy;

  // Idle exactly when no command is latched
  assign busy = (curOp != CMD_NONE);

  // ------------------------------
  // Command FSM
  always_ff @(posedge clk) begin
    if (rst_i) begin
      curOp <= CMD_NONE;
      beat <= '0;
    end else begin
      case (curOp)
        CMD_NONE: begin
          if (bd.start) begin
            curOp <= bd.op;
            selR <= bd.sel;
            addrR <= bd.addr;
            dataR <= bd.wdata;
            beat <= '0;
          end
        end
        default: begin
          if (!selR && mainPort.ack) begin
            // Single 64-bit access
            if (curOp == CMD_READ64) begin
              dataR <= mainPort.rdata;
            end
            curOp <= CMD_NONE;
          end else if (selR && flashPort.ack) begin
            // One byte per beat, LSB first
            if (curOp == CMD_READ64) begin
              dataR[{beat, 3'b000} +: 8] <= flashPort.rdata[7:0];
            end
            beat <= beat + 3'd1;
            if (beat == 3'd7) begin
              curOp <= CMD_NONE;
            end
          end
        end
      endcase
    end
  end

  // Req stays high across beats, the memory acks every other cycle
  assign mainPort.req = busy & ~selR;
  assign mainPort.we = (curOp == CMD_WRITE64);
  assign mainPort.addr = addrR;
  assign mainPort.wdata = dataR;

  assign flashPort.req = busy & selR;
  assign flashPort.we = (curOp == CMD_WRITE64);
  assign flashPort.addr = {addrR, beat};
  assign flashPort.wdata = {{(`SC_DATA_W-8){1'b0}}, dataR[{beat, 3'b000} +: 8]};

  assign bd.busy = busy;
  assign bd.rdata = dataR;

endmodule

/* mainMem.sv */
// Main memory, 64-bit words, no reset and no byte mask
// Acks one cycle after req, read data is registered on the same edge
// A held req gets an ack every other cycle
`timescale 1ns/1ps
`include "sysCtrl_config.svh"

module mainMem
  import sysCtrlPkg::*;
(
  input  logic      clk,
  memPortIf.slave   port
);

  scWord_t  mem [`SC_MAIN_WORDS];
  scWord_t  rdReg;
  logic     ackReg;

  always_ff @(posedge clk) begin
    if (port.req && !ackReg) begin
      if (port.we) begin
        mem[port.addr] <= port.wdata;
      end
      // Old contents on a write, not used by the engine
      rdReg <= mem[port.addr];
      ackReg <= 1'b1;
    end else begin
      ackReg <= 1'b0;
    end
  end

  assign port.rdata = rdReg;
  assign port.ack = ackReg;

endmodule

/* flashMem.sv */
// Byte-wide flash model, only wdata[7:0] is stored
// Same ack rule as main memory, upper rdata bits read as 0
`timescale 1ns/1ps
`include "sysCtrl_config.svh"

module flashMem
  import sysCtrlPkg::*;
(
  input  logic      clk,
  memPortIf.slave   port
);

  scByte_t  mem [`SC_FLASH_BYTES];
  scByte_t  rdByte;
  logic     ackReg;

  always_ff @(posedge clk) begin
    if (port.req && !ackReg) begin
      if (port.we) begin
        mem[port.addr] <= port.wdata[7:0];
      end
      rdByte <= mem[port.addr];
      ackReg <= 1'b1;
    end else begin
      ackReg <= 1'b0;
    end
  end

  assign port.rdata = {{(`SC_DATA_W-8){1'b0}}, rdByte};
  assign port.ack = ackReg;

endmodule

/* coreSequencer.sv */
// Single-thread core sequencer, one reset line per core
// Start holds all cores in reset until loaded, then runs masked cores
// one at a time in ascending order, waiting for pass or fail each
// Start is ignored while busy, done holds until the next start
`timescale 1ns/1ps
`include "sysCtrl_config.svh"

module coreSequencer
  import sysCtrlPkg::*;
(
  input  logic      clk,
  input  logic      rst_i,
  seqCtrlIf.slave   seq,
  input  coreVec_t  corePass_i,
  input  coreVec_t  coreFail_i,
  output coreVec_t  coreReset_o
);

  localparam int IW = $clog2(`SC_NUM_CORES);

  seqState_t      state;
  coreVec_t       maskR;
  coreVec_t       passR;
  coreVec_t       failR;
  logic           doneR;
  logic [IW:0]    idx;
  logic [IW-1:0]  cur;

  assign cur = idx[IW-1:0];

  // ------------------------------
  // Sequencer FSM
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state <= SEQ_IDLE;
      maskR <= '0;
      passR <= '0;
      failR <= '0;
      doneR <= 1'b0;
      idx <= '0;
      coreReset_o <= '0;
    end else begin
      case (state)
        SEQ_IDLE, SEQ_DONE: begin
          if (seq.start) begin
            maskR <= seq.mask;
            passR <= '0;
            failR <= '0;
            doneR <= 1'b0;
            coreReset_o <= '1;
            state <= SEQ_WAIT_LOAD;
          end
        end
        SEQ_WAIT_LOAD: begin
          if (seq.loaded) begin
            idx <= '0;
            state <= SEQ_RELEASE;
          end
        end
        SEQ_RELEASE: begin
          // Skip unmasked cores, finish once past the last index
          if (idx == (IW + 1)'(`SC_NUM_CORES)) begin
            coreReset_o <= '0;
            doneR <= 1'b1;
            state <= SEQ_DONE;
          end else if (maskR[cur]) begin
            coreReset_o[cur] <= 1'b0;
            state <= SEQ_WAIT_RESULT;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        SEQ_WAIT_RESULT: begin
          if (corePass_i[cur] || coreFail_i[cur]) begin
            passR[cur] <= corePass_i[cur];
            failR[cur] <= coreFail_i[cur];
            // Back into reset before the next core runs
            coreReset_o[cur] <= 1'b1;
            idx <= idx + 1'b1;
            state <= SEQ_RELEASE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  assign seq.busy = (state == SEQ_WAIT_LOAD) || (state == SEQ_RELEASE)
                 || (state == SEQ_WAIT_RESULT);
  assign seq.done = doneR;
  assign seq.passMask = passR;
  assign seq.failMask = failR;

endmodule

/* sysCtrlTop.sv */
// System-control top level, Wishbone classic slave on plain ports
// All cores are out of reset until the first sequencer start
// Main memory and flash are separate stores behind one backdoor engine
`timescale 1ns/1ps
`include "sysCtrl_config.svh"

module sysCtrlTop
  import sysCtrlPkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  wbCyc_i,
  input  logic                  wbStb_i,
  input  logic                  wbWe_i,
  input  logic [`SC_WB_AW-1:0]  wbAdr_i,
  input  logic [`SC_WB_DW-1:0]  wbDat_i,
  output logic [`SC_WB_DW-1:0]  wbDat_o,
  output logic                  wbAck_o,
  input  coreVec_t              corePass_i,
  input  coreVec_t              coreFail_i,
  output coreVec_t              coreReset_o
);

  // ------------------------------
  // Internal links
  backdoorIf bdIf ();
  seqCtrlIf seqIf ();
  memPortIf #(.AW(`SC_ADDR_W)) mainIf ();
  memPortIf #(.AW($clog2(`SC_FLASH_BYTES))) flashIf ();

  // Register bank
  dvtFlagRegs uRegs (
    .clk(clk),
    .rst_i(rst_i),
    .wbCyc_i(wbCyc_i),
    .wbStb_i(wbStb_i),
    .wbWe_i(wbWe_i),
    .wbAdr_i(wbAdr_i),
    .wbDat_i(wbDat_i),
    .wbDat_o(wbDat_o),
    .wbAck_o(wbAck_o),
    .bd(bdIf.master),
    .seq(seqIf.master)
  );

  // Backdoor engine and its two stores
  backdoorRouter uRouter (
    .clk(clk),
    .rst_i(rst_i),
    .bd(bdIf.slave),
    .mainPort(mainIf.master),
    .flashPort(flashIf.master)
  );

  mainMem uMain (.clk(clk), .port(mainIf.slave));

  flashMem uFlash (.clk(clk), .port(flashIf.slave));

  // Core reset sequencing
  coreSequencer uSeq (
    .clk(clk),
    .rst_i(rst_i),
    .seq(seqIf.slave),
    .corePass_i(corePass_i),
    .coreFail_i(coreFail_i),
    .coreReset_o(coreReset_o)
  );

endmodule

/* sysCtrl_properties.sv */
// Concurrent checks on the system-control top level, attached by bind
// Wishbone checks are off while reset is high
// seqBusy is the sequencer's own busy, not the STATUS bit
`timescale 1ns/1ps
`include "sysCtrl_config.svh"

module sysCtrlProps
  import sysCtrlPkg::*;
(
  input logic     clk,
  input logic     rst_i,
  input logic     wbCyc_i,
  input logic     wbStb_i,
  input logic     wbAck_o,
  input logic     seqBusy,
  input coreVec_t coreReset_o
);

  int propFailCount = 0;

  // ------------------------------
  // Wishbone ack shape
  ackSinglePulse: assert property (@(posedge clk) disable iff (rst_i)
    wbAck_o |=> !wbAck_o)
    else begin
      propFailCount++;
      $error("wbAck_o stayed high for two cycles");
    end

  // Ack only follows a cycle with cyc and stb high
  ackAfterStrobe: assert property (@(posedge clk) disable iff (rst_i)
    wbAck_o |-> $past(wbCyc_i && wbStb_i))
    else begin
      propFailCount++;
      $error("wbAck_o without cyc and stb one cycle earlier");
    end

  // ------------------------------
  // Core resets
  oneCoreRunning: assert property (@(posedge clk) disable iff (rst_i)
    seqBusy |-> ($countones(~coreReset_o) <= 1))
    else begin
      propFailCount++;
      $error("more than one core out of reset while sequencing");
    end

  resetClearsCores: assert property (@(posedge clk)
    rst_i |=> (coreReset_o == '0))
    else begin
      propFailCount++;
      $error("coreReset_o not 0 after reset");
    end

endmodule

bind sysCtrlTop sysCtrlProps props (
  .clk(clk),
  .rst_i(rst_i),
  .wbCyc_i(wbCyc_i),
  .wbStb_i(wbStb_i),
  .wbAck_o(wbAck_o),
  .seqBusy(seqIf.busy),
  .coreReset_o(coreReset_o)
);

/* sysCtrlTb.sv */
// Testbench for the system-control top level
// Wishbone is driven on the falling edge, one access at a time
// Every wait polls with a limit, running past it ends the run
// Random data comes from a 32-bit Fibonacci LFSR, one step per bit
// Cores answer pass or fail only when the test tells them to
`timescale 1ns/1ps
`include "sysCtrl_config.svh"

module sysCtrlTb
  import sysCtrlPkg::*;
();

  localparam int WAIT_LIMIT = 200;

  logic                  clk;
  logic                  rst_i;
  logic                  wbCyc_i;
  logic                  wbStb_i;
  logic                  wbWe_i;
  logic [`SC_WB_AW-1:0]  wbAdr_i;
  logic [`SC_WB_DW-1:0]  wbDat_i;
  logic [`SC_WB_DW-1:0]  wbDat_o;
  logic                  wbAck_o;
  coreVec_t              corePass_i;
  coreVec_t              coreFail_i;
  coreVec_t              coreReset_o;

  logic [31:0]           lfsr;
  int                    checkCount;
  int                    errorCount;
  logic                  aborted;

  sysCtrlTop dut (
    .clk(clk),
    .rst_i(rst_i),
    .wbCyc_i(wbCyc_i),
    .wbStb_i(wbStb_i),
    .wbWe_i(wbWe_i),
    .wbAdr_i(wbAdr_i),
    .wbDat_i(wbDat_i),
    .wbDat_o(wbDat_o),
    .wbAck_o(wbAck_o),
    .corePass_i(corePass_i),
    .coreFail_i(coreFail_i),
    .coreReset_o(coreReset_o)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ------------------------------
  // Random source, taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic drawBits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      val = {val[62:0], lfsr[0]};
    end
  endtask

  task automatic checkValue(input string what, input logic [63:0] got,
                            input logic [63:0] exp);
    if (!aborted) begin
      checkCount++;
      assert (got === exp) else begin
        errorCount++;
        $display("FAILED %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
    end
  endtask

  task automatic abortRun(input string what);
    aborted = 1'b1;
    $display("Timeout at %0t: gave up waiting for %s", $time, what);
    $display("Test FAILED");
    $finish;
  endtask

  // ------------------------------
  // Wishbone classic access, ack expected one cycle after stb
  task automatic busCycle(input logic we, input logic [`SC_WB_AW-1:0] adr,
                          input logic [31:0] dat, output logic [31:0] rdat);
    int cycles;
    @(negedge clk);
    wbCyc_i = 1'b1;
    wbStb_i = 1'b1;
    wbWe_i = we;
    wbAdr_i = adr;
    wbDat_i = dat;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!wbAck_o && cycles < WAIT_LIMIT);
    rdat = wbDat_o;
    wbCyc_i = 1'b0;
    wbStb_i = 1'b0;
    wbWe_i = 1'b0;
    if (!wbAck_o) begin
      abortRun("Wishbone ack");
    end else begin
      checkValue("cycles from stb to ack", cycles, 1);
    end
  endtask

  task automatic regWrite(input logic [`SC_WB_AW-1:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    busCycle(1'b1, adr, dat, unused);
  endtask

  task automatic regRead(input logic [`SC_WB_AW-1:0] adr, output logic [31:0] dat);
    busCycle(1'b0, adr, 32'h0, dat);
  endtask

  // Poll STATUS until one bit reaches a level
  task automatic waitStatusBit(input int bitIdx, input logic level, input string what,
                               output logic [31:0] rd);
    int polls;
    polls = 0;
    regRead(`SC_REG_STATUS, rd);
    while (rd[bitIdx] !== level && polls < WAIT_LIMIT) begin
      regRead(`SC_REG_STATUS, rd);
      polls++;
    end
    if (rd[bitIdx] !== level) begin
      abortRun(what);
    end
  endtask

  // Selected coreReset_o bits all at one level
  task automatic waitResetBits(input coreVec_t bits, input logic level, input string what);
    coreVec_t want;
    int cycles;
    want = level ? bits : '0;
    cycles = 0;
    while ((coreReset_o & bits) !== want && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if ((coreReset_o & bits) !== want) begin
      abortRun(what);
    end
  endtask

  // ------------------------------
  // Backdoor transfers through the register map
  task automatic memWrite64(input logic [7:0] idx, input logic [63:0] data);
    logic [31:0] rd;
    regWrite(`SC_REG_MADDR, {24'h0, idx});
    regWrite(`SC_REG_MDATA_HI, data[63:32]);
    regWrite(`SC_REG_MDATA_LO, data[31:0]);
    regWrite(`SC_REG_MCMD, 32'(CMD_WRITE64));
    waitStatusBit(0, 1'b0, "memBusy to fall after write64", rd);
  endtask

  // MDATA starts from a fill word that the read has to replace
  task automatic memRead64(input logic [7:0] idx, input logic [63:0] fill,
                           output logic [63:0] data);
    logic [31:0] rd;
    regWrite(`SC_REG_MADDR, {24'h0, idx});
    regWrite(`SC_REG_MDATA_HI, fill[63:32]);
    regWrite(`SC_REG_MDATA_LO, fill[31:0]);
    regWrite(`SC_REG_MCMD, 32'(CMD_READ64));
    waitStatusBit(0, 1'b0, "memBusy to fall after read64", rd);
    regRead(`SC_REG_MDATA_HI, data[63:32]);
    regRead(`SC_REG_MDATA_LO, data[31:0]);
  endtask

  initial begin
    logic [63:0] r;
    logic [63:0] mainData;
    logic [63:0] flashData;
    logic [63:0] firstData;
    logic [63:0] secondData;
    logic [7:0]  idx;
    logic [7:0]  idx2;
    logic [31:0] rd;
    logic [31:0] ctrlVal;
    clk = 1'b0;
    rst_i = 1'b1;
    wbCyc_i = 1'b0;
    wbStb_i = 1'b0;
    wbWe_i = 1'b0;
    wbAdr_i = '0;
    wbDat_i = '0;
    corePass_i = '0;
    coreFail_i = '0;
    lfsr = 32'h5515;
    checkCount = 0;
    errorCount = 0;
    aborted = 1'b0;
    repeat (5) @(negedge clk);
    rst_i = 1'b0;

    // After reset, then CTRL and MADDR read back
    checkValue("wbAck_o after reset", wbAck_o, 0);
    checkValue("coreReset_o after reset", coreReset_o, 0);
    regRead(`SC_REG_STATUS, rd);
    checkValue("STATUS busy and done after reset", rd[2:0], 0);
    drawBits(8, r);
    ctrlVal = r[31:0] & 32'h0000_00F3;
    regWrite(`SC_REG_CTRL, ctrlVal);
    regRead(`SC_REG_CTRL, rd);
    checkValue("CTRL read back", rd, ctrlVal);
    drawBits(8, r);
    regWrite(`SC_REG_MADDR, {24'h0, r[7:0]});
    regRead(`SC_REG_MADDR, rd);
    checkValue("MADDR read back", rd, {24'h0, r[7:0]});

    // Main memory round trip
    regWrite(`SC_REG_CTRL, 32'h0);
    drawBits(8, r);
    idx = r[7:0];
    drawBits(64, mainData);
    memWrite64(idx, mainData);
    memRead64(idx, ~mainData, r);
    checkValue("main memory read64", r, mainData);

    // Flash round trip at the same index, main memory untouched
    regWrite(`SC_REG_CTRL, 32'h1);
    drawBits(64, flashData);
    if (flashData == mainData) begin
      flashData = ~mainData;
    end
    memWrite64(idx, flashData);
    memRead64(idx, ~flashData, r);
    checkValue("flash read64", r, flashData);
    regWrite(`SC_REG_CTRL, 32'h0);
    memRead64(idx, ~mainData, r);
    checkValue("main memory after flash write", r, mainData);

    // ------------------------------
    // Sequencing with mask 1010
    regWrite(`SC_REG_CTRL, 32'h0000_00A4);
    waitResetBits(4'b1111, 1'b1, "all cores held in reset");
    repeat (10) begin
      @(negedge clk);
      checkValue("coreReset_o before load", coreReset_o, 4'b1111);
    end
    regWrite(`SC_REG_CTRL, 32'h0000_00A2);
    waitResetBits(4'b0010, 1'b0, "core 1 release");
    checkValue("coreReset_o with core 1 running", coreReset_o, 4'b1101);
    corePass_i = 4'b0010;
    @(negedge clk);
    corePass_i = '0;
    waitResetBits(4'b1000, 1'b0, "core 3 release");
    checkValue("coreReset_o with core 3 running", coreReset_o, 4'b0111);
    coreFail_i = 4'b1000;
    @(negedge clk);
    coreFail_i = '0;
    waitStatusBit(2, 1'b1, "seqDone", rd);
    checkValue("seqBusy after done", rd[1], 0);
    checkValue("passMask", rd[7:4], 4'b0010);
    checkValue("failMask", rd[11:8], 4'b1000);
    checkValue("coreReset_o after done", coreReset_o, 0);

    // Second MCMD during a flash write is dropped
    regWrite(`SC_REG_CTRL, 32'h1);
    drawBits(8, r);
    idx2 = r[7:0];
    drawBits(64, firstData);
    drawBits(64, secondData);
    if (secondData == firstData) begin
      secondData = ~firstData;
    end
    regWrite(`SC_REG_MADDR, {24'h0, idx2});
    regWrite(`SC_REG_MDATA_HI, firstData[63:32]);
    regWrite(`SC_REG_MDATA_LO, firstData[31:0]);
    regWrite(`SC_REG_MCMD, 32'(CMD_WRITE64));
    regWrite(`SC_REG_MDATA_HI, secondData[63:32]);
    regWrite(`SC_REG_MDATA_LO, secondData[31:0]);
    regRead(`SC_REG_STATUS, rd);
    checkValue("memBusy before second MCMD", rd[0], 1);
    regWrite(`SC_REG_MCMD, 32'(CMD_WRITE64));
    waitStatusBit(0, 1'b0, "memBusy to fall after dropped command", rd);
    memRead64(idx2, ~firstData, r);
    checkValue("flash data after dropped command", r, firstData);

    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checkCount, errorCount, dut.props.propFailCount);
    if (errorCount == 0 && dut.props.propFailCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+.
sysCtrlPkg.sv
sysCtrlIfs.sv
dvtFlagRegs.sv
backdoorRouter.sv
mainMem.sv
flashMem.sv
coreSequencer.sv
sysCtrlTop.sv
sysCtrl_properties.sv
sysCtrlTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator, pass only on Test OK
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module sysCtrlTb

# Assertion errors must not stop the run before the summary
out=$(./obj_dir/VsysCtrlTb +verilator+error+limit+1000 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Test OK'
